// ==== hdl/zpu_exec_pkg.sv ====
package zpu_exec_pkg;

    localparam int WORD_W  = 32;
    localparam int DMEM_AW = 26;

    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [DMEM_AW-1:0] dmem_addr_t;

    // decoder operation codes
    typedef enum logic [4:0] {
        op_nop,
        op_mov,
        op_im0,
        op_imn,
        op_add,
        op_addsp,
        op_sub,
        op_and,
        op_or,
        op_not,
        op_flip,
        op_eq,
        op_lessthan,
        op_ulessthan,
        op_mul,
        op_load,
        op_store,
        op_store2,
        op_loadsp,
        op_storesp
    } exec_op_e;

    typedef struct packed {
        exec_op_e   op;
        logic [6:0] imm;
        dmem_addr_t dest_addr;
        word_t      operand;
        dmem_addr_t operand_addr;
    } exec_in_t;

    typedef struct packed {
        word_t tos;
        word_t nos;
    } stack_pair_t;

    typedef struct packed {
        logic       en;
        logic [3:0] wmask;
        dmem_addr_t addr;
        word_t      data;
    } mem_req_t;

    typedef enum logic [2:0] {
        tos_keep,
        tos_alu,
        tos_nos,
        tos_operand,
        tos_mul,
        tos_load
    } tos_sel_e;

    typedef enum logic [1:0] {
        nos_keep,
        nos_tos,
        nos_operand
    } nos_sel_e;

    typedef enum logic [2:0] {
        mem_none,
        mem_wr_result,
        mem_wr_tos,
        mem_wr_store,
        mem_rd_load
    } mem_cmd_e;

endpackage

// ==== hdl/exec_ctrl.sv ====
`timescale 1ns/1ps

module exec_ctrl #(
    parameter int MUL_STAGES = 2
) (
    input  logic                   clk,
    input  logic                   rst,
    input  zpu_exec_pkg::exec_op_e op_i,
    output logic                   stall_o,
    output zpu_exec_pkg::tos_sel_e tos_sel_o,
    output zpu_exec_pkg::nos_sel_e nos_sel_o,
    output zpu_exec_pkg::mem_cmd_e mem_cmd_o,
    output logic                   mul_start_o
);

    localparam int CNT_W = $clog2(MUL_STAGES + 1);

    typedef enum logic [1:0] {
        st_exec,
        st_mul_wait,
        st_load_wait,
        st_load_done
    } state_e;

    state_e           state_q;
    state_e           state_d;
    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] cnt_d;
    logic             mul_last;

    // product is in the last stage
    assign mul_last = (cnt_q == CNT_W'(MUL_STAGES));

    always_comb begin
        unique case (state_q)
            st_exec:      stall_o = (op_i == zpu_exec_pkg::op_mul) ||
                                    (op_i == zpu_exec_pkg::op_load);
            st_mul_wait:  stall_o = !mul_last;
            st_load_wait: stall_o = 1'b1;
            default:      stall_o = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////
    // per-operation stack update and memory command
    //////////////////////////////////////////////////

    always_comb begin
        tos_sel_o   = zpu_exec_pkg::tos_keep;
        nos_sel_o   = zpu_exec_pkg::nos_keep;
        mem_cmd_o   = zpu_exec_pkg::mem_none;
        mul_start_o = 1'b0;
        state_d     = state_q;
        cnt_d       = cnt_q;
        unique case (state_q)
            st_exec: begin
                unique case (op_i)
                    zpu_exec_pkg::op_mov: begin
                        tos_sel_o = zpu_exec_pkg::tos_nos;
                        nos_sel_o = zpu_exec_pkg::nos_operand;
                    end
                    // push a new word
                    zpu_exec_pkg::op_im0, zpu_exec_pkg::op_loadsp: begin
                        tos_sel_o = zpu_exec_pkg::tos_alu;
                        nos_sel_o = zpu_exec_pkg::nos_tos;
                        mem_cmd_o = zpu_exec_pkg::mem_wr_result;
                    end
                    zpu_exec_pkg::op_imn, zpu_exec_pkg::op_not,
                    zpu_exec_pkg::op_flip, zpu_exec_pkg::op_addsp: begin
                        tos_sel_o = zpu_exec_pkg::tos_alu;
                        mem_cmd_o = zpu_exec_pkg::mem_wr_result;
                    end
                    // two operands in, one out
                    zpu_exec_pkg::op_add, zpu_exec_pkg::op_sub,
                    zpu_exec_pkg::op_and, zpu_exec_pkg::op_or,
                    zpu_exec_pkg::op_eq, zpu_exec_pkg::op_lessthan,
                    zpu_exec_pkg::op_ulessthan: begin
                        tos_sel_o = zpu_exec_pkg::tos_alu;
                        nos_sel_o = zpu_exec_pkg::nos_operand;
                        mem_cmd_o = zpu_exec_pkg::mem_wr_result;
                    end
                    zpu_exec_pkg::op_storesp: begin
                        tos_sel_o = zpu_exec_pkg::tos_nos;
                        nos_sel_o = zpu_exec_pkg::nos_operand;
                        mem_cmd_o = zpu_exec_pkg::mem_wr_tos;
                    end
                    zpu_exec_pkg::op_store: begin
                        tos_sel_o = zpu_exec_pkg::tos_operand;
                        mem_cmd_o = zpu_exec_pkg::mem_wr_store;
                    end
                    zpu_exec_pkg::op_store2: begin
                        nos_sel_o = zpu_exec_pkg::nos_operand;
                    end
                    zpu_exec_pkg::op_mul: begin
                        nos_sel_o   = zpu_exec_pkg::nos_operand;
                        mul_start_o = 1'b1;
                        cnt_d       = CNT_W'(1);
                        state_d     = st_mul_wait;
                    end
                    zpu_exec_pkg::op_load: begin
                        mem_cmd_o = zpu_exec_pkg::mem_rd_load;
                        state_d   = st_load_wait;
                    end
                    default: ;
                endcase
            end
            st_mul_wait: begin
                if (mul_last) begin
                    tos_sel_o = zpu_exec_pkg::tos_mul;
                    mem_cmd_o = zpu_exec_pkg::mem_wr_result;
                    state_d   = st_exec;
                end else begin
                    cnt_d = cnt_q + CNT_W'(1);
                end
            end
            // read data arrives while in load_done
            st_load_wait: state_d = st_load_done;
            default: begin
                tos_sel_o = zpu_exec_pkg::tos_load;
                mem_cmd_o = zpu_exec_pkg::mem_wr_result;
                state_d   = st_exec;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= st_exec;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
        end
    end

endmodule

// ==== hdl/stack_alu.sv ====
`timescale 1ns/1ps

module stack_alu (
    input  zpu_exec_pkg::exec_op_e    op_i,
    input  logic [6:0]                imm_i,
    input  zpu_exec_pkg::stack_pair_t stack_i,
    input  zpu_exec_pkg::word_t       operand_i,
    output zpu_exec_pkg::word_t       result_o
);

    localparam int W = zpu_exec_pkg::WORD_W;

    logic signed [W-1:0] tos_s;
    logic signed [W-1:0] nos_s;
    zpu_exec_pkg::word_t flipped;
    logic                eq;
    logic                lt;
    logic                ult;

    assign tos_s = stack_i.tos;
    assign nos_s = stack_i.nos;
    assign eq    = (stack_i.tos == stack_i.nos);
    assign lt    = (tos_s < nos_s);
    assign ult   = (stack_i.tos < stack_i.nos);

    // bit reverse of tos
    always_comb begin
        for (int i = 0; i < W; i++) begin
            flipped[i] = stack_i.tos[W-1-i];
        end
    end

    always_comb begin
        unique case (op_i)
            zpu_exec_pkg::op_add:       result_o = stack_i.tos + stack_i.nos;
            zpu_exec_pkg::op_addsp:     result_o = stack_i.tos + operand_i;
            zpu_exec_pkg::op_sub:       result_o = stack_i.nos - stack_i.tos;
            zpu_exec_pkg::op_and:       result_o = stack_i.tos & stack_i.nos;
            zpu_exec_pkg::op_or:        result_o = stack_i.tos | stack_i.nos;
            zpu_exec_pkg::op_not:       result_o = ~stack_i.tos;
            zpu_exec_pkg::op_flip:      result_o = flipped;
            zpu_exec_pkg::op_eq:        result_o = {{(W-1){1'b0}}, eq};
            zpu_exec_pkg::op_lessthan:  result_o = {{(W-1){1'b0}}, lt};
            zpu_exec_pkg::op_ulessthan: result_o = {{(W-1){1'b0}}, ult};
            // immediates build the word 7 bits at a time
            zpu_exec_pkg::op_im0:       result_o = {{(W-7){imm_i[6]}}, imm_i};
            zpu_exec_pkg::op_imn:       result_o = {stack_i.tos[W-8:0], imm_i};
            zpu_exec_pkg::op_loadsp:    result_o = operand_i;
            default:                    result_o = '0;
        endcase
    end

endmodule

// ==== hdl/stack_regs.sv ====
`timescale 1ns/1ps

module stack_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  zpu_exec_pkg::tos_sel_e    tos_sel_i,
    input  zpu_exec_pkg::nos_sel_e    nos_sel_i,
    input  zpu_exec_pkg::word_t       alu_i,
    input  zpu_exec_pkg::word_t       operand_i,
    input  zpu_exec_pkg::word_t       mul_i,
    input  zpu_exec_pkg::word_t       load_i,
    output zpu_exec_pkg::stack_pair_t stack_o,
    output zpu_exec_pkg::word_t       next_tos_o
);

    zpu_exec_pkg::stack_pair_t stack_q;
    zpu_exec_pkg::stack_pair_t stack_d;

    // next top of stack
    always_comb begin
        unique case (tos_sel_i)
            zpu_exec_pkg::tos_alu:     stack_d.tos = alu_i;
            zpu_exec_pkg::tos_nos:     stack_d.tos = stack_q.nos;
            zpu_exec_pkg::tos_operand: stack_d.tos = operand_i;
            zpu_exec_pkg::tos_mul:     stack_d.tos = mul_i;
            zpu_exec_pkg::tos_load:    stack_d.tos = load_i;
            default:                   stack_d.tos = stack_q.tos;
        endcase
    end

    // next second word
    always_comb begin
        unique case (nos_sel_i)
            zpu_exec_pkg::nos_tos:     stack_d.nos = stack_q.tos;
            zpu_exec_pkg::nos_operand: stack_d.nos = operand_i;
            default:                   stack_d.nos = stack_q.nos;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stack_q <= '0;
        end else begin
            stack_q <= stack_d;
        end
    end

    assign stack_o    = stack_q;
    assign next_tos_o = stack_d.tos;

endmodule

// ==== hdl/mul_pipe.sv ====
`timescale 1ns/1ps

module mul_pipe #(
    parameter int MUL_STAGES = 2
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                start_i,
    input  zpu_exec_pkg::word_t a_i,
    input  zpu_exec_pkg::word_t b_i,
    output zpu_exec_pkg::word_t product_o
);

    zpu_exec_pkg::word_t stage_q [MUL_STAGES];

    // first stage takes the product on start and the rest shift behind it
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MUL_STAGES; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            if (start_i) begin
                stage_q[0] <= $signed(a_i) * $signed(b_i);
            end
            for (int i = 1; i < MUL_STAGES; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign product_o = stage_q[MUL_STAGES-1];

endmodule

// ==== hdl/stack_wr_fwd.sv ====
`timescale 1ns/1ps

module stack_wr_fwd #(
    parameter int FWD_DEPTH = 2
) (
    input  logic                      clk,
    input  logic                      rst,
    input  zpu_exec_pkg::mem_cmd_e    cmd_i,
    input  zpu_exec_pkg::stack_pair_t stack_i,
    input  zpu_exec_pkg::word_t       next_tos_i,
    input  zpu_exec_pkg::dmem_addr_t  dest_addr_i,
    input  zpu_exec_pkg::word_t       operand_i,
    input  zpu_exec_pkg::dmem_addr_t  operand_addr_i,
    output zpu_exec_pkg::mem_req_t    dmem_req_o,
    output zpu_exec_pkg::word_t       operand_o
);

    localparam int AW = zpu_exec_pkg::DMEM_AW;

    zpu_exec_pkg::mem_req_t   req_d;
    zpu_exec_pkg::mem_req_t   req_q;
    zpu_exec_pkg::dmem_addr_t tos_addr;
    logic                     is_write;
    logic                     fwd_vld  [FWD_DEPTH];
    logic [AW-3:0]            fwd_addr [FWD_DEPTH];
    zpu_exec_pkg::word_t      fwd_data [FWD_DEPTH];

    // word aligned address held in tos
    assign tos_addr = {stack_i.tos[AW-1:2], 2'b00};
    assign is_write = (req_d.wmask != 4'h0);

    always_comb begin
        req_d.en    = 1'b1;
        req_d.wmask = 4'hf;
        req_d.addr  = dest_addr_i;
        req_d.data  = next_tos_i;
        unique case (cmd_i)
            zpu_exec_pkg::mem_wr_result: ;
            zpu_exec_pkg::mem_wr_tos:    req_d.data = stack_i.tos;
            zpu_exec_pkg::mem_wr_store: begin
                req_d.addr = tos_addr;
                req_d.data = stack_i.nos;
            end
            zpu_exec_pkg::mem_rd_load: begin
                req_d.wmask = 4'h0;
                req_d.addr  = tos_addr;
            end
            default: begin
                req_d.en    = 1'b0;
                req_d.wmask = 4'h0;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // request register and write history
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            req_q.en    <= 1'b0;
            req_q.wmask <= 4'h0;
            for (int i = 0; i < FWD_DEPTH; i++) begin
                fwd_vld[i] <= 1'b0;
            end
        end else begin
            req_q <= req_d;
            if (is_write) begin
                fwd_vld[0]  <= 1'b1;
                fwd_addr[0] <= req_d.addr[AW-1:2];
                fwd_data[0] <= req_d.data;
                for (int i = 1; i < FWD_DEPTH; i++) begin
                    fwd_vld[i]  <= fwd_vld[i-1];
                    fwd_addr[i] <= fwd_addr[i-1];
                    fwd_data[i] <= fwd_data[i-1];
                end
            end
        end
    end

    // oldest first so the newest match wins
    always_comb begin
        operand_o = operand_i;
        for (int i = FWD_DEPTH - 1; i >= 0; i--) begin
            if (fwd_vld[i] && (fwd_addr[i] == operand_addr_i[AW-1:2])) begin
                operand_o = fwd_data[i];
            end
        end
    end

    assign dmem_req_o = req_q;

endmodule

// ==== hdl/zpu_exec_top.sv ====
`timescale 1ns/1ps

module zpu_exec_top #(
    parameter int MUL_STAGES = 2,
    parameter int FWD_DEPTH  = 2
) (
    input  logic                      clk,
    input  logic                      rst,
    input  zpu_exec_pkg::exec_in_t    inst_i,
    output logic                      stall_o,
    output zpu_exec_pkg::mem_req_t    dmem_req_o,
    input  zpu_exec_pkg::word_t       dmem_rdata_i,
    output zpu_exec_pkg::stack_pair_t stack_o
);

    zpu_exec_pkg::tos_sel_e    tos_sel;
    zpu_exec_pkg::nos_sel_e    nos_sel;
    zpu_exec_pkg::mem_cmd_e    mem_cmd;
    logic                      mul_start;
    zpu_exec_pkg::stack_pair_t stack;
    zpu_exec_pkg::word_t       next_tos;
    zpu_exec_pkg::word_t       alu_result;
    zpu_exec_pkg::word_t       mul_product;
    zpu_exec_pkg::word_t       fwd_operand;

    assign stack_o = stack;

    exec_ctrl #(
        .MUL_STAGES(MUL_STAGES)
    ) u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .op_i       (inst_i.op),
        .stall_o    (stall_o),
        .tos_sel_o  (tos_sel),
        .nos_sel_o  (nos_sel),
        .mem_cmd_o  (mem_cmd),
        .mul_start_o(mul_start)
    );

    stack_alu u_alu (
        .op_i     (inst_i.op),
        .imm_i    (inst_i.imm),
        .stack_i  (stack),
        .operand_i(fwd_operand),
        .result_o (alu_result)
    );

    stack_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .tos_sel_i (tos_sel),
        .nos_sel_i (nos_sel),
        .alu_i     (alu_result),
        .operand_i (fwd_operand),
        .mul_i     (mul_product),
        .load_i    (dmem_rdata_i),
        .stack_o   (stack),
        .next_tos_o(next_tos)
    );

    mul_pipe #(
        .MUL_STAGES(MUL_STAGES)
    ) u_mul (
        .clk      (clk),
        .rst      (rst),
        .start_i  (mul_start),
        .a_i      (stack.tos),
        .b_i      (stack.nos),
        .product_o(mul_product)
    );

    stack_wr_fwd #(
        .FWD_DEPTH(FWD_DEPTH)
    ) u_wr_fwd (
        .clk           (clk),
        .rst           (rst),
        .cmd_i         (mem_cmd),
        .stack_i       (stack),
        .next_tos_i    (next_tos),
        .dest_addr_i   (inst_i.dest_addr),
        .operand_i     (inst_i.operand),
        .operand_addr_i(inst_i.operand_addr),
        .dmem_req_o    (dmem_req_o),
        .operand_o     (fwd_operand)
    );

endmodule

// ==== verif/zpu_exec_assert.sv ====
`timescale 1ns/1ps

module zpu_exec_assert #(
    parameter int MUL_STAGES = 2,
    parameter int FWD_DEPTH  = 2
) (
    input logic                      clk,
    input logic                      rst,
    input zpu_exec_pkg::exec_in_t    inst_i,
    input logic                      stall_o,
    input zpu_exec_pkg::mem_req_t    dmem_req_o,
    input zpu_exec_pkg::stack_pair_t stack_o
);

    localparam int AW = zpu_exec_pkg::DMEM_AW;

    int                  err_cnt = 0;
    int                  stall_run;
    logic                alu_op;
    logic                wb_op;
    logic                cur_wr;
    zpu_exec_pkg::word_t exp_operand;
    zpu_exec_pkg::word_t alu_exp;
    zpu_exec_pkg::word_t mul_a;
    zpu_exec_pkg::word_t mul_b;
    zpu_exec_pkg::word_t mul_exp;
    zpu_exec_pkg::word_t st_addr;
    zpu_exec_pkg::word_t st_data;
    logic                st_vld;
    logic                hist_vld  [FWD_DEPTH];
    logic [AW-3:0]       hist_addr [FWD_DEPTH];
    zpu_exec_pkg::word_t hist_data [FWD_DEPTH];

    function automatic zpu_exec_pkg::word_t alu_model(input zpu_exec_pkg::exec_op_e op,
            input logic [6:0] imm, input zpu_exec_pkg::word_t tos,
            input zpu_exec_pkg::word_t nos, input zpu_exec_pkg::word_t opnd);
        zpu_exec_pkg::word_t r;
        r = '0;
        case (op)
            zpu_exec_pkg::op_add:       r = tos + nos;
            zpu_exec_pkg::op_addsp:     r = tos + opnd;
            zpu_exec_pkg::op_sub:       r = nos - tos;
            zpu_exec_pkg::op_and:       r = tos & nos;
            zpu_exec_pkg::op_or:        r = tos | nos;
            zpu_exec_pkg::op_not:       r = ~tos;
            zpu_exec_pkg::op_flip: begin
                for (int i = 0; i < 32; i++) begin
                    r[i] = tos[31-i];
                end
            end
            zpu_exec_pkg::op_eq:        r = (tos == nos) ? 32'd1 : 32'd0;
            zpu_exec_pkg::op_lessthan:  r = ($signed(tos) < $signed(nos)) ? 32'd1 : 32'd0;
            zpu_exec_pkg::op_ulessthan: r = (tos < nos) ? 32'd1 : 32'd0;
            zpu_exec_pkg::op_im0:       r = {{25{imm[6]}}, imm};
            zpu_exec_pkg::op_imn:       r = (tos << 7) | {25'd0, imm};
            zpu_exec_pkg::op_loadsp:    r = opnd;
            default:                    r = '0;
        endcase
        return r;
    endfunction

    assign alu_op = inst_i.op inside {zpu_exec_pkg::op_add, zpu_exec_pkg::op_addsp,
        zpu_exec_pkg::op_sub, zpu_exec_pkg::op_and, zpu_exec_pkg::op_or, zpu_exec_pkg::op_not,
        zpu_exec_pkg::op_flip, zpu_exec_pkg::op_eq, zpu_exec_pkg::op_lessthan,
        zpu_exec_pkg::op_ulessthan, zpu_exec_pkg::op_im0, zpu_exec_pkg::op_imn,
        zpu_exec_pkg::op_loadsp};
    assign wb_op   = alu_op || (inst_i.op inside {zpu_exec_pkg::op_mul, zpu_exec_pkg::op_load});
    assign cur_wr  = dmem_req_o.en && (dmem_req_o.wmask == 4'hf);
    assign mul_exp = $signed(mul_a) * $signed(mul_b);
    assign alu_exp = alu_model(inst_i.op, inst_i.imm, stack_o.tos, stack_o.nos, exp_operand);

    // newest write to the operand's word wins and the one on the bus counts too
    always_comb begin
        int j;
        exp_operand = inst_i.operand;
        for (int i = FWD_DEPTH - 1; i >= 0; i--) begin
            j = cur_wr ? i - 1 : i;
            if (cur_wr && i == 0) begin
                if (dmem_req_o.addr[AW-1:2] == inst_i.operand_addr[AW-1:2]) begin
                    exp_operand = dmem_req_o.data;
                end
            end else if (hist_vld[j] && hist_addr[j] == inst_i.operand_addr[AW-1:2]) begin
                exp_operand = hist_data[j];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stall_run <= 0;
            st_vld    <= 1'b0;
            for (int i = 0; i < FWD_DEPTH; i++) begin
                hist_vld[i] <= 1'b0;
            end
        end else begin
            stall_run <= stall_o ? stall_run + 1 : 0;
            if (cur_wr) begin
                hist_vld[0]  <= 1'b1;
                hist_addr[0] <= dmem_req_o.addr[AW-1:2];
                hist_data[0] <= dmem_req_o.data;
                for (int i = 1; i < FWD_DEPTH; i++) begin
                    hist_vld[i]  <= hist_vld[i-1];
                    hist_addr[i] <= hist_addr[i-1];
                    hist_data[i] <= hist_data[i-1];
                end
            end
            // operands of a multiply as first presented
            if (inst_i.op == zpu_exec_pkg::op_mul && stall_o && stall_run == 0) begin
                mul_a <= stack_o.tos;
                mul_b <= stack_o.nos;
            end
            if (inst_i.op == zpu_exec_pkg::op_store && !stall_o) begin
                st_vld  <= 1'b1;
                st_addr <= stack_o.tos;
                st_data <= stack_o.nos;
            end
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    a_reset: assert property (@(posedge clk)
        rst |=> (!stall_o && !dmem_req_o.en && stack_o == '0))
        else begin
            err_cnt++;
            $error("Fail %0t: outputs not cleared by reset", $time);
        end

    a_alu: assert property (@(posedge clk)
        (!rst && alu_op && !stall_o) |=> (stack_o.tos == $past(alu_exp)))
        else begin
            err_cnt++;
            $error("Fail %0t: tos %h after alu op, expected %h", $time, stack_o.tos,
                $past(alu_exp));
        end

    a_wb: assert property (@(posedge clk)
        (!rst && wb_op && !stall_o) |=> (dmem_req_o.en && dmem_req_o.wmask == 4'hf &&
            dmem_req_o.addr == $past(inst_i.dest_addr) && dmem_req_o.data == stack_o.tos))
        else begin
            err_cnt++;
            $error("Fail %0t: write-back request wrong", $time);
        end

    a_stall_len: assert property (@(posedge clk)
        (!rst && !stall_o && inst_i.op inside {zpu_exec_pkg::op_mul, zpu_exec_pkg::op_load})
        |-> (stall_run == ((inst_i.op == zpu_exec_pkg::op_mul) ? MUL_STAGES : 2)))
        else begin
            err_cnt++;
            $error("Fail %0t: stall lasted %0d cycles", $time, stall_run);
        end

    a_mul: assert property (@(posedge clk)
        (!rst && inst_i.op == zpu_exec_pkg::op_mul && !stall_o) |=> (stack_o.tos == mul_exp))
        else begin
            err_cnt++;
            $error("Fail %0t: product %h, expected %h", $time, stack_o.tos, mul_exp);
        end

    a_store: assert property (@(posedge clk)
        (!rst && inst_i.op == zpu_exec_pkg::op_store && !stall_o) |=> (dmem_req_o.en &&
            dmem_req_o.wmask == 4'hf && dmem_req_o.data == $past(stack_o.nos) &&
            dmem_req_o.addr == {$past(stack_o.tos[AW-1:2]), 2'b00} &&
            stack_o.tos == $past(exp_operand)))
        else begin
            err_cnt++;
            $error("Fail %0t: store request or tos wrong", $time);
        end

    a_load: assert property (@(posedge clk)
        (!rst && inst_i.op == zpu_exec_pkg::op_load && !stall_o && st_vld &&
            stack_o.tos[AW-1:2] == st_addr[AW-1:2]) |=> (stack_o.tos == st_data))
        else begin
            err_cnt++;
            $error("Fail %0t: loaded %h, expected %h", $time, stack_o.tos, st_data);
        end

endmodule

bind zpu_exec_top zpu_exec_assert #(
    .MUL_STAGES(MUL_STAGES),
    .FWD_DEPTH (FWD_DEPTH)
) u_chk (
    .clk       (clk),
    .rst       (rst),
    .inst_i    (inst_i),
    .stall_o   (stall_o),
    .dmem_req_o(dmem_req_o),
    .stack_o   (stack_o)
);

// ==== verif/tb_zpu_exec.sv ====
`timescale 1ns/1ps

module tb_zpu_exec;

    localparam int MUL_STAGES = 2;
    localparam int FWD_DEPTH  = 2;
    localparam int WAIT_LIMIT = 20;

    logic                      clk;
    logic                      rst;
    zpu_exec_pkg::exec_in_t    inst;
    logic                      stall;
    zpu_exec_pkg::mem_req_t    dmem_req;
    zpu_exec_pkg::word_t       dmem_rdata;
    zpu_exec_pkg::stack_pair_t stack;
    zpu_exec_pkg::word_t       mem [256];
    int                        n_tests;
    int                        err_seen;

    zpu_exec_pkg::exec_op_e alu_ops [13] = '{zpu_exec_pkg::op_add, zpu_exec_pkg::op_addsp,
        zpu_exec_pkg::op_sub, zpu_exec_pkg::op_and, zpu_exec_pkg::op_or, zpu_exec_pkg::op_not,
        zpu_exec_pkg::op_flip, zpu_exec_pkg::op_eq, zpu_exec_pkg::op_lessthan,
        zpu_exec_pkg::op_ulessthan, zpu_exec_pkg::op_im0, zpu_exec_pkg::op_imn,
        zpu_exec_pkg::op_loadsp};

    zpu_exec_top #(
        .MUL_STAGES(MUL_STAGES),
        .FWD_DEPTH (FWD_DEPTH)
    ) DUT (
        .clk         (clk),
        .rst         (rst),
        .inst_i      (inst),
        .stall_o     (stall),
        .dmem_req_o  (dmem_req),
        .dmem_rdata_i(dmem_rdata),
        .stack_o     (stack)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // word memory with read data one cycle after the request
    always @(posedge clk) begin
        if (dmem_req.en) begin
            if (dmem_req.wmask == 4'hf) begin
                mem[dmem_req.addr[9:2]] <= dmem_req.data;
            end else begin
                dmem_rdata <= #1 mem[dmem_req.addr[9:2]];
            end
        end
    end

    function automatic zpu_exec_pkg::dmem_addr_t rand_addr();
        return zpu_exec_pkg::dmem_addr_t'($urandom_range(255, 64) << 2);
    endfunction

    // hold the instruction until an edge with stall low takes it
    task automatic issue(input zpu_exec_pkg::exec_op_e op, input logic [6:0] imm,
            input zpu_exec_pkg::dmem_addr_t dest, input zpu_exec_pkg::word_t operand,
            input zpu_exec_pkg::dmem_addr_t opaddr);
        int waited;
        inst   = '{op, imm, dest, operand, opaddr};
        waited = 0;
        @(negedge clk);
        while (stall && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (stall) begin
            $display("timeout: stall_o still high after %0d cycles at %0t", WAIT_LIMIT, $time);
            $display("test failed");
            $finish;
        end else begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic issue_rand(input zpu_exec_pkg::exec_op_e op, input logic [6:0] imm);
        issue(op, imm, rand_addr(), $urandom(), rand_addr());
    endtask

    // im0 then four imn build a full word
    task automatic push_word(input zpu_exec_pkg::word_t w);
        issue_rand(zpu_exec_pkg::op_im0, {{3{w[31]}}, w[31:28]});
        issue_rand(zpu_exec_pkg::op_imn, w[27:21]);
        issue_rand(zpu_exec_pkg::op_imn, w[20:14]);
        issue_rand(zpu_exec_pkg::op_imn, w[13:7]);
        issue_rand(zpu_exec_pkg::op_imn, w[6:0]);
    endtask

    task automatic end_test(input string name);
        int errs;
        inst = '0;
        repeat (2) @(posedge clk);
        #1;
        errs     = DUT.u_chk.err_cnt - err_seen;
        err_seen = DUT.u_chk.err_cnt;
        n_tests++;
        $display("%-10s finished, %0d assertion failures", name, errs);
    endtask

    initial begin
        zpu_exec_pkg::word_t      data;
        logic [6:0]               addr7;
        zpu_exec_pkg::dmem_addr_t fwd_a;
        int                       total;
        void'($urandom(32'h74f2efa7));
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'h3c000000 ^ (i * 32'h00010203);
        end
        rst        = 1'b1;
        inst       = '0;
        dmem_rdata = '0;
        n_tests    = 0;
        err_seen   = 0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        end_test("reset");

        repeat (40) issue_rand(alu_ops[$urandom_range(12, 0)], 7'($urandom()));
        end_test("alu");

        push_word($urandom());
        push_word($urandom());
        end_test("writeback");

        ////////////////////////////////////////////////
        // operand word written one and two instructions back
        repeat (4) begin
            fwd_a = rand_addr();
            issue(zpu_exec_pkg::op_im0, 7'($urandom()), fwd_a, $urandom(), rand_addr());
            issue(zpu_exec_pkg::op_addsp, 7'h0, rand_addr(), 32'hdeadbeef, fwd_a);
            issue(zpu_exec_pkg::op_im0, 7'($urandom()), fwd_a, $urandom(), rand_addr());
            issue_rand(zpu_exec_pkg::op_not, 7'h0);
            issue(zpu_exec_pkg::op_addsp, 7'h0, rand_addr(), 32'hdeadbeef, fwd_a);
        end
        end_test("forward");

        repeat (4) begin
            push_word($urandom());
            push_word($urandom());
            issue_rand(zpu_exec_pkg::op_mul, 7'h0);
        end
        end_test("multiply");

        // store addresses stay below the write-back region
        repeat (3) begin
            data  = $urandom();
            addr7 = {1'b0, 4'($urandom()), 2'b00};
            push_word(data);
            issue_rand(zpu_exec_pkg::op_im0, addr7);
            issue_rand(zpu_exec_pkg::op_store, 7'h0);
            issue_rand(zpu_exec_pkg::op_im0, addr7);
            issue_rand(zpu_exec_pkg::op_load, 7'h0);
        end
        end_test("loadstore");

        total = DUT.u_chk.err_cnt;
        $display("%0d tests run, %0d assertion failures", n_tests, total);
        if (total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
hdl/zpu_exec_pkg.sv
hdl/exec_ctrl.sv
hdl/stack_alu.sv
hdl/stack_regs.sv
hdl/mul_pipe.sv
hdl/stack_wr_fwd.sv
hdl/zpu_exec_top.sv
verif/zpu_exec_assert.sv
verif/tb_zpu_exec.sv
